// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= tb_vector_sequencer
FILELIST  ?= sources.f
PASS_MSG  := Test completed successfully

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build output"
	@echo "  help   list these targets"

obj_dir/V$(TOP): $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

test: obj_dir/V$(TOP)
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf obj_dir

// ==== dv/tb_vector_sequencer.sv ====
`timescale 1ns/1ps

`include "seq_cfg.svh"

module tb_vector_sequencer import seq_op_pkg::*; import seq_state_pkg::*; ();

  localparam int TIMEOUT = 200;

  // DUT ports
  logic                    clk_i, rst_ni;
  seq_req_t                req;
  logic                    req_valid, req_ready;
  logic [NR_PES-1:0]       pe_ready;
  vid_vec_t [NR_PES-1:0]   pe_done;
  logic                    alu_done, mfpu_done;
  pe_req_t                 pe_req;
  logic                    pe_valid, idle;
  vid_vec_t                running;
  vid_vec_t [NR_VINSN-1:0] haz_table;

  // Reference model state
  vid_vec_t                m_running, m_running_d, done_vec;
  vid_vec_t [NR_VINSN-1:0] m_table;
  vfu_vec_t                done_unit, req_tgt;
  logic                    m_pe_valid, lanes_ok, exp_ready, xfer;
  int                      m_cnt [NR_VFUS];
  vid_t                    w_vid [`SEQ_NR_VREGS];
  vid_t                    r_vid [`SEQ_NR_VREGS];
  logic                    w_val [`SEQ_NR_VREGS];
  logic                    r_val [`SEQ_NR_VREGS];
  seq_op_e                 id_op [NR_VINSN];
  logic                    id_vm [NR_VINSN];
  int                      issue_cyc [NR_VINSN];
  vid_t                    exp_id, exp_q_id;
  vid_vec_t                exp_vs1, exp_vs2, exp_vm, exp_vd;
  vid_vec_t [3:0]          exp_q_haz;
  seq_req_t                exp_q_req;
  vfu_e                    exp_q_vfu;

  // Run control
  int                      xfer_count, cyc, errors, timeouts;
  logic                    hold_done, rand_lanes, force_lane_low, check_reset;
  logic [31:0]             lfsr_state = 32'h18e6;

  vector_sequencer dut_i (
    .clk_i                (clk_i),
    .rst_ni               (rst_ni),
    .req_i                (req),
    .req_valid_i          (req_valid),
    .req_ready_o          (req_ready),
    .pe_req_ready_i       (pe_ready),
    .pe_done_i            (pe_done),
    .alu_done_i           (alu_done),
    .mfpu_done_i          (mfpu_done),
    .pe_req_o             (pe_req),
    .pe_req_valid_o       (pe_valid),
    .pe_vinsn_running_o   (running),
    .global_hazard_table_o(haz_table),
    .idle_o               (idle)
  );

  initial begin
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////////////////////////////////////////

  // Fibonacci LFSR, taps 32 22 2 1, one step per bit taken
  function automatic logic [31:0] rand_bits(int n);
    logic [31:0] r;
    logic        fb;
    r = '0;
    for (int i = 0; i < n; i++) begin
      fb         = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
      lfsr_state = {lfsr_state[30:0], fb};
      r          = {r[30:0], fb};
    end
    return r;
  endfunction

  // Unit that runs each op
  function automatic vfu_e unit_of(seq_op_e op);
    case (op)
      VADD, VSUB, VMSEQ: return VFU_ALU;
      VMUL, VFADD:       return VFU_MFPU;
      VLE:               return VFU_LOAD;
      default:           return VFU_STORE;
    endcase
  endfunction

  // Queues an op holds, its own unit plus the mask unit when it touches a mask
  function automatic vfu_vec_t targets_of(seq_op_e op, logic vm);
    vfu_vec_t t;
    t = '0;
    case (op)
      VADD, VSUB:  t[VFU_ALU] = 1'b1;
      VMSEQ:       t = vfu_vec_t'((1 << VFU_ALU) | (1 << VFU_MASK));
      VMUL, VFADD: t[VFU_MFPU] = 1'b1;
      VLE:         t[VFU_LOAD] = 1'b1;
      default:     t[VFU_STORE] = 1'b1;
    endcase
    if (!vm) t[VFU_MASK] = 1'b1;
    return t;
  endfunction

  function automatic int depth_of(int u);
    case (u)
      0:       return `SEQ_ALU_DEPTH;
      1:       return `SEQ_MFPU_DEPTH;
      2:       return `SEQ_LOAD_DEPTH;
      3:       return `SEQ_STORE_DEPTH;
      default: return `SEQ_MASK_DEPTH;
    endcase
  endfunction

  // Registers limited to v0..v7 so hazards show up often
  function automatic seq_req_t random_req();
    seq_req_t    r;
    logic [2:0]  o;
    r    = '0;
    o    = 3'(rand_bits(3) % 7);
    r.op = seq_op_e'(o);
    r.vs1 = 5'(rand_bits(3));
    r.vs2 = 5'(rand_bits(3));
    r.vd  = 5'(rand_bits(3));
    r.vm  = rand_bits(2) != 0;
    r.vl  = 10'(rand_bits(10));
    case (r.op)
      VLE: r.use_vd = 1'b1;
      VSE: r.use_vs1 = 1'b1;
      default: begin
        r.use_vs1 = 1'b1;
        r.use_vs2 = 1'b1;
        r.use_vd  = 1'b1;
      end
    endcase
    return r;
  endfunction

  function automatic seq_req_t fixed_req(seq_op_e op);
    seq_req_t r;
    r        = '0;
    r.op     = op;
    r.vm     = 1'b1;
    r.vd     = 5'd3;
    r.use_vd = 1'b1;
    return r;
  endfunction

  task automatic report_mismatch(string name, logic [63:0] exp, logic [63:0] act);
    errors++;
    $display("[ERROR] %s expected 0x%0h actual 0x%0h", name, exp, act);
  endtask

  task automatic print_summary();
    $display("Summary: %0d check errors, %0d timeouts", errors, timeouts);
  endtask

  task automatic count_timeout(string what);
    timeouts++;
    $display("Timeout while waiting for %s", what);
  endtask

  // Called on a falling edge, returns on the falling edge after the transfer
  task automatic wait_transfer(int n0);
    int t;
    for (t = 0; t < TIMEOUT; t++) begin
      @(negedge clk_i);
      if (xfer_count != n0) break;
    end
    if (t == TIMEOUT) count_timeout("a request transfer");
    req_valid = 1'b0;
  endtask

  task automatic send(seq_req_t r);
    req       = r;
    req_valid = 1'b1;
    wait_transfer(xfer_count);
  endtask

  task automatic wait_idle();
    int t;
    for (t = 0; t < TIMEOUT; t++) begin
      if (m_running == '0 && !m_pe_valid) break;
      @(negedge clk_i);
    end
    if (t == TIMEOUT) count_timeout("all instructions to finish");
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    logic found;
    found   = 1'b0;
    exp_id  = '0;
    for (int i = 0; i < NR_VINSN; i++) begin
      if (!found && !m_running[i]) begin
        exp_id = vid_t'(i);
        found  = 1'b1;
      end
    end
    req_tgt  = targets_of(req.op, req.vm);
    lanes_ok = &pe_ready[NR_LANES-1:0];
    // Ready needs a free lane bus, a free ID and room in every target queue
    exp_ready = !(m_pe_valid && !lanes_ok) && found;
    for (int u = 0; u < NR_VFUS; u++) begin
      if (req_tgt[u] && m_cnt[u] >= depth_of(u)) exp_ready = 1'b0;
    end
    xfer = req_valid && exp_ready;
    // RAW on used sources and on the mask, only against live writers
    exp_vs1 = '0;
    exp_vs2 = '0;
    exp_vm  = '0;
    exp_vd  = '0;
    if (req.use_vs1 && w_val[req.vs1] && m_running[w_vid[req.vs1]]) begin
      exp_vs1[w_vid[req.vs1]] = 1'b1;
    end
    if (req.use_vs2 && w_val[req.vs2] && m_running[w_vid[req.vs2]]) begin
      exp_vs2[w_vid[req.vs2]] = 1'b1;
    end
    if (!req.vm && w_val[`SEQ_VMASK_REG] && m_running[w_vid[`SEQ_VMASK_REG]])
      exp_vm[w_vid[`SEQ_VMASK_REG]] = 1'b1;
    if (req.use_vd) begin
      // WAR goes on every operand port, WAW on vd
      if (r_val[req.vd] && m_running[r_vid[req.vd]]) begin
        exp_vs1[r_vid[req.vd]] = 1'b1;
        exp_vs2[r_vid[req.vd]] = 1'b1;
        exp_vm[r_vid[req.vd]]  = 1'b1;
      end
      if (w_val[req.vd] && m_running[w_vid[req.vd]]) exp_vd[w_vid[req.vd]] = 1'b1;
    end
    m_running_d = (m_running & ~done_vec) | (xfer ? (vid_vec_t'(1) << exp_id) : '0);
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      m_running  <= '0;
      m_pe_valid <= 1'b0;
      m_table    <= '0;
      xfer_count <= 0;
      cyc        <= 0;
      for (int v = 0; v < `SEQ_NR_VREGS; v++) begin
        w_val[v] <= 1'b0;
        r_val[v] <= 1'b0;
        w_vid[v] <= '0;
        r_vid[v] <= '0;
      end
      for (int u = 0; u < NR_VFUS; u++) m_cnt[u] <= 0;
    end else begin
      cyc        <= cyc + 1;
      m_running  <= m_running_d;
      m_pe_valid <= xfer || (m_pe_valid && !lanes_ok);
      // Transfers as seen on the DUT handshake
      if (req_valid && req_ready) xfer_count <= xfer_count + 1;
      // Entries of finished IDs fall out of the lists
      for (int v = 0; v < `SEQ_NR_VREGS; v++) begin
        w_val[v] <= w_val[v] && m_running[w_vid[v]];
        r_val[v] <= r_val[v] && m_running[r_vid[v]];
      end
      for (int u = 0; u < NR_VFUS; u++) begin
        if (xfer && req_tgt[u] && !done_unit[u]) m_cnt[u] <= m_cnt[u] + 1;
        else if (done_unit[u] && !(xfer && req_tgt[u])) m_cnt[u] <= m_cnt[u] - 1;
      end
      for (int i = 0; i < NR_VINSN; i++) m_table[i] <= m_table[i] & m_running_d;
      if (xfer) begin
        id_op[exp_id]    <= req.op;
        id_vm[exp_id]    <= req.vm;
        issue_cyc[exp_id] <= cyc;
        exp_q_id         <= exp_id;
        exp_q_haz        <= {exp_vs1, exp_vs2, exp_vm, exp_vd};
        exp_q_req        <= req;
        exp_q_vfu        <= unit_of(req.op);
        m_table[exp_id]  <= (exp_vs1 | exp_vs2 | exp_vm | exp_vd) & m_running_d;
        if (req.use_vd) begin
          w_vid[req.vd] <= exp_id;
          w_val[req.vd] <= 1'b1;
        end
        if (req.use_vs1) begin
          r_vid[req.vs1] <= exp_id;
          r_val[req.vs1] <= 1'b1;
        end
        if (req.use_vs2) begin
          r_vid[req.vs2] <= exp_id;
          r_val[req.vs2] <= 1'b1;
        end
        if (!req.vm) begin
          r_vid[`SEQ_VMASK_REG] <= exp_id;
          r_val[`SEQ_VMASK_REG] <= 1'b1;
        end
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // PE side, lane readies and done pulses
  ////////////////////////////////////////////////////////////////////////////

  // At most one completion per cycle, so each unit frees one slot at a time
  always @(negedge clk_i) begin : drive_pe
    logic        picked;
    logic [31:0] lane_pick;
    vfu_vec_t    t;
    pe_done   = '0;
    alu_done  = 1'b0;
    mfpu_done = 1'b0;
    done_vec  = '0;
    done_unit = '0;
    picked    = 1'b0;
    pe_ready  = '1;
    if (force_lane_low) begin
      pe_ready[0] = 1'b0;
    end else if (rand_lanes && rand_bits(3) == 0) begin
      lane_pick = rand_bits(2);
      for (int l = 0; l < NR_LANES; l++) begin
        if (lane_pick == l) pe_ready[l] = 1'b0;
      end
    end
    if (rst_ni && !hold_done && rand_bits(2) != 0) begin
      for (int i = 0; i < NR_VINSN; i++) begin
        if (!picked && m_running[i] && cyc >= issue_cyc[i] + 2) begin
          picked      = 1'b1;
          t           = targets_of(id_op[i], id_vm[i]);
          done_vec[i] = 1'b1;
          done_unit   = t;
          alu_done    = t[VFU_ALU];
          mfpu_done   = t[VFU_MFPU];
          // Arithmetic finishes on the lanes, memory ops on their own PE
          for (int l = 0; l < NR_LANES; l++) begin
            if (t[VFU_ALU] || t[VFU_MFPU]) pe_done[l][i] = 1'b1;
          end
          pe_done[PE_LOAD][i]  = t[VFU_LOAD];
          pe_done[PE_STORE][i] = t[VFU_STORE];
          pe_done[PE_MASK][i]  = t[VFU_MASK];
        end
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Checks
  ////////////////////////////////////////////////////////////////////////////

  logic [4:0] reset_status;
  assign reset_status = {req_ready, idle, pe_valid, running != '0, haz_table != '0};

  // Request fields as the PEs see them, unit on top
  logic [$bits(seq_req_t)+2:0] pe_fields;
  assign pe_fields = {pe_req.vfu, pe_req.op, pe_req.vs1, pe_req.vs2, pe_req.vd,
                      pe_req.use_vs1, pe_req.use_vs2, pe_req.use_vd, pe_req.vm, pe_req.vl};

  assert property (@(posedge clk_i) check_reset |-> reset_status == 5'b11000)
    else report_mismatch("reset_state", 64'(5'b11000), 64'($sampled(reset_status)));

  assert property (@(posedge clk_i) disable iff (!rst_ni) req_ready == exp_ready)
    else report_mismatch("req_ready", 64'($sampled(exp_ready)), 64'($sampled(req_ready)));

  assert property (@(posedge clk_i) disable iff (!rst_ni) pe_valid == m_pe_valid)
    else report_mismatch("pe_req_valid", 64'($sampled(m_pe_valid)), 64'($sampled(pe_valid)));

  assert property (@(posedge clk_i) disable iff (!rst_ni) running == m_running)
    else report_mismatch("running", 64'($sampled(m_running)), 64'($sampled(running)));

  assert property (@(posedge clk_i) disable iff (!rst_ni) idle == (m_running == '0))
    else report_mismatch("idle", 64'($sampled(m_running == '0)), 64'($sampled(idle)));

  assert property (@(posedge clk_i) disable iff (!rst_ni) pe_valid |-> pe_req.id == exp_q_id)
    else report_mismatch("issue_id", 64'($sampled(exp_q_id)), 64'($sampled(pe_req.id)));

  assert property (@(posedge clk_i) disable iff (!rst_ni)
    pe_valid |-> pe_fields == {exp_q_vfu, exp_q_req})
    else report_mismatch("payload", 64'($sampled({exp_q_vfu, exp_q_req})),
      64'($sampled(pe_fields)));

  // Hazard vectors packed vs1, vs2, vm, vd from top to bottom
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    pe_valid |-> {pe_req.hazard_vs1, pe_req.hazard_vs2, pe_req.hazard_vm, pe_req.hazard_vd}
                 == exp_q_haz)
    else report_mismatch("hazards", 64'($sampled(exp_q_haz)),
      64'($sampled({pe_req.hazard_vs1, pe_req.hazard_vs2, pe_req.hazard_vm, pe_req.hazard_vd})));

  assert property (@(posedge clk_i) disable iff (!rst_ni) haz_table == m_table)
    else report_mismatch("hazard_table", 64'($sampled(m_table)), 64'($sampled(haz_table)));

  assert property (@(posedge clk_i) disable iff (!rst_ni)
    pe_valid && !lanes_ok |=> pe_valid && $stable(pe_req))
    else begin
      errors++;
      $display("[ERROR] lane_stall: PE request dropped or changed while a lane was not ready");
    end

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    int n0;
    req            = '0;
    req_valid      = 1'b0;
    pe_ready       = '1;
    pe_done        = '0;
    alu_done       = 1'b0;
    mfpu_done      = 1'b0;
    done_vec       = '0;
    done_unit      = '0;
    hold_done      = 1'b0;
    rand_lanes     = 1'b0;
    force_lane_low = 1'b0;
    check_reset    = 1'b0;
    errors         = 0;
    timeouts       = 0;
    rst_ni         = 1'b0;
    repeat (10) @(negedge clk_i);
    rst_ni      = 1'b1;
    check_reset = 1'b1;
    @(negedge clk_i);
    check_reset = 1'b0;

    // Random traffic with lane stalls
    rand_lanes = 1'b1;
    for (int n = 0; n < 150; n++) begin
      send(random_req());
      if (rand_bits(2) == 0) @(negedge clk_i);
    end
    rand_lanes = 1'b0;

    // Fill every ID, then a load waits for a free one
    wait_idle();
    hold_done = 1'b1;
    for (int n = 0; n < 4; n++) send(fixed_req(VADD));
    for (int n = 0; n < 4; n++) send(fixed_req(VMUL));
    req       = fixed_req(VLE);
    req_valid = 1'b1;
    n0        = xfer_count;
    repeat (3) @(negedge clk_i);
    hold_done = 1'b0;
    wait_transfer(n0);

    // Load queue full until one load completes
    wait_idle();
    hold_done = 1'b1;
    send(fixed_req(VLE));
    send(fixed_req(VLE));
    req       = fixed_req(VLE);
    req_valid = 1'b1;
    n0        = xfer_count;
    repeat (3) @(negedge clk_i);
    hold_done = 1'b0;
    wait_transfer(n0);

    // Lane 0 holds the broadcast
    wait_idle();
    force_lane_low = 1'b1;
    send(fixed_req(VSUB));
    req       = fixed_req(VFADD);
    req_valid = 1'b1;
    n0        = xfer_count;
    repeat (4) @(negedge clk_i);
    force_lane_low = 1'b0;
    wait_transfer(n0);
    wait_idle();

    print_summary();
    if (errors == 0 && timeouts == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

// ==== source/seq_cfg.svh ====
`ifndef SEQ_CFG_SVH
`define SEQ_CFG_SVH

// Number of vector lanes
`define SEQ_NR_LANES 4

// Instruction IDs that can be in flight at once
`define SEQ_NR_VINSN 8

// Architectural vector register file
`define SEQ_NR_VREGS 32

// Register holding the mask operand
`define SEQ_VMASK_REG 0

// Width of the vector length field
`define SEQ_VL_W 10

// Instruction queue depth of each functional unit
`define SEQ_ALU_DEPTH   4
`define SEQ_MFPU_DEPTH  4
`define SEQ_LOAD_DEPTH  2
`define SEQ_STORE_DEPTH 2
`define SEQ_MASK_DEPTH  2

// Occupancy counter width, wide enough for the deepest queue
`define SEQ_CNT_W 3

`endif

// ==== source/seq_op_pkg.sv ====
`include "seq_cfg.svh"

package seq_op_pkg;

  // Register index and vector length
  typedef logic [4:0]           vreg_t;
  typedef logic [`SEQ_VL_W-1:0] vlen_t;

  // Supported vector operations
  typedef enum logic [2:0] {
    VADD,
    VSUB,
    VMSEQ,
    VMUL,
    VFADD,
    VLE,
    VSE
  } seq_op_e;

  // Functional units, the value is also the bit index in vfu_vec_t
  typedef enum logic [2:0] {
    VFU_ALU,
    VFU_MFPU,
    VFU_LOAD,
    VFU_STORE,
    VFU_MASK
  } vfu_e;

  localparam int unsigned NR_VFUS = 5;

  typedef logic [NR_VFUS-1:0] vfu_vec_t;

  // Decoded instruction coming from the dispatcher
  typedef struct packed {
    seq_op_e op;
    vreg_t   vs1;
    vreg_t   vs2;
    vreg_t   vd;
    logic    use_vs1;
    logic    use_vs2;
    logic    use_vd;
    logic    vm;      // 1 means unmasked
    vlen_t   vl;
  } seq_req_t;

  // Unit that executes the operation
  function automatic vfu_e op_vfu(seq_op_e op);
    case (op)
      VADD, VSUB, VMSEQ: op_vfu = VFU_ALU;
      VMUL, VFADD:       op_vfu = VFU_MFPU;
      VLE:               op_vfu = VFU_LOAD;
      VSE:               op_vfu = VFU_STORE;
      default:           op_vfu = VFU_ALU;
    endcase
  endfunction

  // Every unit whose queue the operation occupies
  function automatic vfu_vec_t op_targets(seq_op_e op, logic vm);
    op_targets = '0;
    op_targets[op_vfu(op)] = 1'b1;
    // Compares write a mask, masked ops read one
    if (op == VMSEQ || !vm) begin
      op_targets[VFU_MASK] = 1'b1;
    end
  endfunction

endpackage

// ==== source/seq_state_pkg.sv ====
`include "seq_cfg.svh"

package seq_state_pkg;

  localparam int unsigned NR_LANES = `SEQ_NR_LANES;
  localparam int unsigned NR_VINSN = `SEQ_NR_VINSN;

  // PEs are the lanes, then load, store and mask unit
  localparam int unsigned NR_PES   = NR_LANES + 3;
  localparam int unsigned PE_LOAD  = NR_LANES;
  localparam int unsigned PE_STORE = NR_LANES + 1;
  localparam int unsigned PE_MASK  = NR_LANES + 2;

  // Instruction ID and one-hot-per-ID vector
  typedef logic [$clog2(NR_VINSN)-1:0] vid_t;
  typedef logic [NR_VINSN-1:0]         vid_vec_t;

  // Request broadcast to the PEs
  typedef struct packed {
    vid_t                id;
    seq_op_pkg::seq_op_e op;
    seq_op_pkg::vfu_e    vfu;
    seq_op_pkg::vreg_t   vs1;
    seq_op_pkg::vreg_t   vs2;
    seq_op_pkg::vreg_t   vd;
    logic                use_vs1;
    logic                use_vs2;
    logic                use_vd;
    logic                vm;
    seq_op_pkg::vlen_t   vl;
    // IDs this instruction must wait on, per operand
    vid_vec_t            hazard_vs1;
    vid_vec_t            hazard_vs2;
    vid_vec_t            hazard_vm;
    vid_vec_t            hazard_vd;
  } pe_req_t;

  // Last reader or writer of a vector register
  typedef struct packed {
    vid_t vid;
    logic valid;
  } vreg_access_t;

endpackage

// ==== source/vector_sequencer.sv ====
`timescale 1ns/1ps

module vector_sequencer import seq_op_pkg::*; import seq_state_pkg::*; (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  // Dispatcher
  input  seq_req_t                req_i,
  input  logic                    req_valid_i,
  output logic                    req_ready_o,
  // Processing elements
  input  logic [NR_PES-1:0]       pe_req_ready_i,
  input  vid_vec_t [NR_PES-1:0]   pe_done_i,
  input  logic                    alu_done_i,
  input  logic                    mfpu_done_i,
  output pe_req_t                 pe_req_o,
  output logic                    pe_req_valid_o,
  output vid_vec_t                pe_vinsn_running_o,
  // Operand requesters, row per ID
  output vid_vec_t [NR_VINSN-1:0] global_hazard_table_o,
  output logic                    idle_o
);

  vid_t                    next_id;
  logic                    id_full;
  vid_vec_t                running_next;
  vid_vec_t                hazard_vs1, hazard_vs2, hazard_vm, hazard_vd;
  vfu_e                    req_vfu;
  vfu_vec_t                targets, unit_ready, unit_done;
  logic [NR_PES-1:0]       issue_pes;
  logic                    lanes_ready, pe_stall, queue_ok, issue;
  vid_vec_t [NR_VINSN-1:0] hazard_table_d;

  ////////////////////////////////////////////////////////////////////////////
  // Issue decision
  ////////////////////////////////////////////////////////////////////////////

  assign req_vfu = op_vfu(req_i.op);
  assign targets = op_targets(req_i.op, req_i.vm);

  // Only the lanes gate the broadcast
  assign lanes_ready = &pe_req_ready_i[NR_LANES-1:0];
  assign pe_stall    = pe_req_valid_o & ~lanes_ready;

  // Every targeted unit needs a free queue slot
  assign queue_ok = &(unit_ready | ~targets);

  assign req_ready_o = ~pe_stall & ~id_full & queue_ok;
  assign issue       = req_valid_i & req_ready_o;

  // Arithmetic runs on all lanes, memory ops on their unit
  // mask unit joins whenever it holds a queue slot
  always_comb begin
    issue_pes = '0;
    case (req_vfu)
      VFU_LOAD:  issue_pes[PE_LOAD]  = 1'b1;
      VFU_STORE: issue_pes[PE_STORE] = 1'b1;
      default:   issue_pes[NR_LANES-1:0] = '1;
    endcase
    issue_pes[PE_MASK] = targets[VFU_MASK];
  end

  // Non-lane units release a slot on any of their done bits
  always_comb begin
    unit_done            = '0;
    unit_done[VFU_LOAD]  = |pe_done_i[PE_LOAD];
    unit_done[VFU_STORE] = |pe_done_i[PE_STORE];
    unit_done[VFU_MASK]  = |pe_done_i[PE_MASK];
  end

  vinsn_tracker i_tracker (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .issue_i       (issue),
    .issue_id_i    (next_id),
    .issue_pes_i   (issue_pes),
    .pe_done_i     (pe_done_i),
    .next_id_o     (next_id),
    .id_full_o     (id_full),
    .running_o     (pe_vinsn_running_o),
    .running_next_o(running_next),
    .idle_o        (idle_o)
  );

  vreg_scoreboard i_scoreboard (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .req_i       (req_i),
    .issue_i     (issue),
    .issue_id_i  (next_id),
    .running_i   (pe_vinsn_running_o),
    .hazard_vs1_o(hazard_vs1),
    .hazard_vs2_o(hazard_vs2),
    .hazard_vm_o (hazard_vm),
    .hazard_vd_o (hazard_vd)
  );

  vfu_queue_credits i_credits (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .issue_i     (issue),
    .targets_i   (targets),
    .alu_done_i  (alu_done_i),
    .mfpu_done_i (mfpu_done_i),
    .unit_done_i (unit_done),
    .unit_ready_o(unit_ready)
  );

  ////////////////////////////////////////////////////////////////////////////
  // PE request register
  ////////////////////////////////////////////////////////////////////////////

  // Valid stays up while any lane is stalling
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      pe_req_valid_o <= 1'b0;
    end else begin
      pe_req_valid_o <= issue | pe_stall;
    end
  end

  // Payload loads only on issue, so it holds through a stall
  always_ff @(posedge clk_i) begin
    if (issue) begin
      pe_req_o <= '{
        id:         next_id,
        op:         req_i.op,
        vfu:        req_vfu,
        vs1:        req_i.vs1,
        vs2:        req_i.vs2,
        vd:         req_i.vd,
        use_vs1:    req_i.use_vs1,
        use_vs2:    req_i.use_vs2,
        use_vd:     req_i.use_vd,
        vm:         req_i.vm,
        vl:         req_i.vl,
        hazard_vs1: hazard_vs1,
        hazard_vs2: hazard_vs2,
        hazard_vm:  hazard_vm,
        hazard_vd:  hazard_vd
      };
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Global hazard table
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    // Forget dependencies on IDs that finish
    for (int unsigned i = 0; i < NR_VINSN; i++) begin
      hazard_table_d[i] = global_hazard_table_o[i] & running_next;
    end
    // Row of the new ID
    if (issue) begin
      hazard_table_d[next_id] = (hazard_vs1 | hazard_vs2 | hazard_vm | hazard_vd) & running_next;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      global_hazard_table_o <= '0;
    end else begin
      global_hazard_table_o <= hazard_table_d;
    end
  end

endmodule

// ==== source/vfu_queue_credits.sv ====
`timescale 1ns/1ps

`include "seq_cfg.svh"

module vfu_queue_credits import seq_op_pkg::*; (
  input  logic     clk_i,
  input  logic     rst_ni,
  // Issue and the units it occupies
  input  logic     issue_i,
  input  vfu_vec_t targets_i,
  // Slot release pulses
  input  logic     alu_done_i,
  input  logic     mfpu_done_i,
  input  vfu_vec_t unit_done_i,
  // Unit has a free queue slot
  output vfu_vec_t unit_ready_o
);

  localparam int unsigned CNT_W = `SEQ_CNT_W;

  typedef logic [CNT_W-1:0] cnt_t;

  // Depth per unit, element index follows vfu_e
  localparam cnt_t [NR_VFUS-1:0] DEPTH = {
    cnt_t'(`SEQ_MASK_DEPTH),
    cnt_t'(`SEQ_STORE_DEPTH),
    cnt_t'(`SEQ_LOAD_DEPTH),
    cnt_t'(`SEQ_MFPU_DEPTH),
    cnt_t'(`SEQ_ALU_DEPTH)
  };

  cnt_t [NR_VFUS-1:0] cnt_q;
  vfu_vec_t           cnt_up, cnt_down;

  // ALU and MFPU report through their own pulses
  always_comb begin
    cnt_down           = unit_done_i;
    cnt_down[VFU_ALU]  = alu_done_i;
    cnt_down[VFU_MFPU] = mfpu_done_i;
  end

  assign cnt_up = {NR_VFUS{issue_i}} & targets_i;

  // Up on issue, down on release, hold when both
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cnt_q <= '0;
    end else begin
      for (int unsigned i = 0; i < NR_VFUS; i++) begin
        if (cnt_up[i] && !cnt_down[i]) begin
          cnt_q[i] <= cnt_q[i] + cnt_t'(1);
        end else if (cnt_down[i] && !cnt_up[i]) begin
          cnt_q[i] <= cnt_q[i] - cnt_t'(1);
        end
      end
    end
  end

  for (genvar i = 0; i < NR_VFUS; i++) begin : gen_unit
    assign unit_ready_o[i] = cnt_q[i] < DEPTH[i];

    // Issue is held back by the ready bit at the top level
    assert property (@(posedge clk_i) disable iff (!rst_ni) cnt_q[i] <= DEPTH[i])
      else $error("unit %0d queue count above depth", i);

    // A release needs an occupied slot
    assert property (@(posedge clk_i) disable iff (!rst_ni)
      cnt_down[i] && !cnt_up[i] |-> cnt_q[i] != '0)
      else $error("unit %0d queue count below zero", i);
  end

endmodule

// ==== source/vinsn_tracker.sv ====
`timescale 1ns/1ps

module vinsn_tracker import seq_state_pkg::*; (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  // New instruction and the PEs it runs on
  input  logic                  issue_i,
  input  vid_t                  issue_id_i,
  input  logic [NR_PES-1:0]     issue_pes_i,
  // Completion pulses, one vector per PE
  input  vid_vec_t [NR_PES-1:0] pe_done_i,
  // Allocation and status
  output vid_t                  next_id_o,
  output logic                  id_full_o,
  output vid_vec_t              running_o,
  output vid_vec_t              running_next_o,
  output logic                  idle_o
);

  ////////////////////////////////////////////////////////////////////////////
  // Running matrix
  ////////////////////////////////////////////////////////////////////////////

  // Row per PE, bit per ID
  vid_vec_t [NR_PES-1:0] pe_running_d, pe_running_q;
  vid_vec_t              running_q;

  always_comb begin
    running_next_o = '0;
    for (int unsigned pe = 0; pe < NR_PES; pe++) begin
      // Done pulses retire the ID on that PE
      pe_running_d[pe] = pe_running_q[pe] & ~pe_done_i[pe];
      // Set the column of the new ID on every target PE
      if (issue_i && issue_pes_i[pe]) begin
        pe_running_d[pe][issue_id_i] = 1'b1;
      end
      // Running anywhere
      running_next_o |= pe_running_d[pe];
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      pe_running_q <= '0;
      running_q    <= '0;
    end else begin
      pe_running_q <= pe_running_d;
      running_q    <= running_next_o;
    end
  end

  assign running_o = running_q;

  ////////////////////////////////////////////////////////////////////////////
  // Free ID search
  ////////////////////////////////////////////////////////////////////////////

  // Lowest clear bit wins, scan from the top so the last hit is the lowest
  always_comb begin
    next_id_o = '0;
    for (int i = NR_VINSN - 1; i >= 0; i--) begin
      if (!running_q[i]) begin
        next_id_o = vid_t'(i);
      end
    end
  end

  assign id_full_o = &running_q;
  assign idle_o    = ~|running_q;

  // Top level must gate issue with the full flag
  assert property (@(posedge clk_i) disable iff (!rst_ni) issue_i |-> !id_full_o)
    else $error("issue while every instruction ID is running");

endmodule

// ==== source/vreg_scoreboard.sv ====
`timescale 1ns/1ps

`include "seq_cfg.svh"

module vreg_scoreboard import seq_op_pkg::*; import seq_state_pkg::*; (
  input  logic     clk_i,
  input  logic     rst_ni,
  // Incoming instruction
  input  seq_req_t req_i,
  input  logic     issue_i,
  input  vid_t     issue_id_i,
  // IDs still executing
  input  vid_vec_t running_i,
  // Hazards of the incoming instruction
  output vid_vec_t hazard_vs1_o,
  output vid_vec_t hazard_vs2_o,
  output vid_vec_t hazard_vm_o,
  output vid_vec_t hazard_vd_o
);

  localparam vreg_t VMASK = vreg_t'(`SEQ_VMASK_REG);

  // Last reader and last writer of each register
  vreg_access_t [`SEQ_NR_VREGS-1:0] read_list_d, read_list_q;
  vreg_access_t [`SEQ_NR_VREGS-1:0] write_list_d, write_list_q;

  // Lists with finished instructions removed
  vreg_access_t [`SEQ_NR_VREGS-1:0] read_live, write_live;

  always_comb begin
    for (int unsigned v = 0; v < `SEQ_NR_VREGS; v++) begin
      read_live[v]        = read_list_q[v];
      read_live[v].valid  = read_list_q[v].valid & running_i[read_list_q[v].vid];
      write_live[v]       = write_list_q[v];
      write_live[v].valid = write_list_q[v].valid & running_i[write_list_q[v].vid];
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Hazard detection
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    hazard_vs1_o = '0;
    hazard_vs2_o = '0;
    hazard_vm_o  = '0;
    hazard_vd_o  = '0;

    // RAW on the sources
    if (req_i.use_vs1 && write_live[req_i.vs1].valid) begin
      hazard_vs1_o[write_live[req_i.vs1].vid] = 1'b1;
    end
    if (req_i.use_vs2 && write_live[req_i.vs2].valid) begin
      hazard_vs2_o[write_live[req_i.vs2].vid] = 1'b1;
    end
    // RAW on the mask register
    if (!req_i.vm && write_live[VMASK].valid) begin
      hazard_vm_o[write_live[VMASK].vid] = 1'b1;
    end

    // WAR, destination still being read
    // flagged on all operand ports so no reader gets overtaken
    if (req_i.use_vd && read_live[req_i.vd].valid) begin
      hazard_vs1_o[read_live[req_i.vd].vid] = 1'b1;
      hazard_vs2_o[read_live[req_i.vd].vid] = 1'b1;
      hazard_vm_o[read_live[req_i.vd].vid]  = 1'b1;
    end

    // WAW on the destination
    if (req_i.use_vd && write_live[req_i.vd].valid) begin
      hazard_vd_o[write_live[req_i.vd].vid] = 1'b1;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // List update
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    read_list_d  = read_live;
    write_list_d = write_live;
    if (issue_i) begin
      // New writer of vd
      if (req_i.use_vd) begin
        write_list_d[req_i.vd] = '{vid: issue_id_i, valid: 1'b1};
      end
      // New reader of its sources and of the mask
      if (req_i.use_vs1) begin
        read_list_d[req_i.vs1] = '{vid: issue_id_i, valid: 1'b1};
      end
      if (req_i.use_vs2) begin
        read_list_d[req_i.vs2] = '{vid: issue_id_i, valid: 1'b1};
      end
      if (!req_i.vm) begin
        read_list_d[VMASK] = '{vid: issue_id_i, valid: 1'b1};
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      read_list_q  <= '0;
      write_list_q <= '0;
    end else begin
      read_list_q  <= read_list_d;
      write_list_q <= write_list_d;
    end
  end

endmodule

// ==== sources.f ====
+incdir+source
source/seq_op_pkg.sv
source/seq_state_pkg.sv
source/vinsn_tracker.sv
source/vreg_scoreboard.sv
source/vfu_queue_credits.sv
source/vector_sequencer.sv
dv/tb_vector_sequencer.sv
